//--- rtl/west_defines.svh
`ifndef WEST_DEFINES_SVH
`define WEST_DEFINES_SVH

// Pad ring of the west side
`define WEST_NUM_PADS 32

// Write port widths
`define WEST_ADDR_W 5
`define WEST_DATA_W 10

// Bias word to the analog macros
`define WEST_VB_W 4

// Configuration register map
`define WEST_REG_CTRL   5'd0
`define WEST_REG_REFDIV 5'd1
`define WEST_REG_VB     5'd2
`define WEST_REG_SEED   5'd3

// Bits of the control register
`define WEST_CTRL_TRNG_EN  0
`define WEST_CTRL_NOISE_EN 1
`define WEST_CTRL_REF_EN   2

`endif

//--- rtl/west_pkg.sv
`default_nettype none

`include "west_defines.svh"

package west_pkg;

    // One strobe on the pad write port
    typedef struct packed {
        logic                    valid;
        logic [`WEST_ADDR_W-1:0] addr;
        logic [`WEST_DATA_W-1:0] data;
    } cfg_write_t;

    typedef struct packed {
        logic                    trng_en;
        logic                    noise_en;
        logic                    ref_en;
        logic [`WEST_DATA_W-1:0] ref_div;
        logic [`WEST_VB_W-1:0]   vb;
        logic [`WEST_DATA_W-1:0] seed;
        logic                    seed_load;
    } west_cfg_t;

    // Drive from the core into the analog macros
    typedef struct packed {
        logic                  clktrng;
        logic                  clkref;
        logic                  clknoise;
        logic [`WEST_VB_W-1:0] vb;
    } macro_ctrl_t;

    // Levels coming back from the analog macros
    typedef struct packed {
        logic clkro;
        logic lock;
        logic clkpll;
        logic clkpll0;
        logic clkpll1;
        logic iout;
    } macro_stat_t;

    typedef struct packed {
        logic [`WEST_NUM_PADS-1:0] dq;
        logic [`WEST_NUM_PADS-1:0] drv0;
        logic [`WEST_NUM_PADS-1:0] drv1;
        logic [`WEST_NUM_PADS-1:0] drv2;
        logic [`WEST_NUM_PADS-1:0] enabq;
        logic [`WEST_NUM_PADS-1:0] enq;
        logic [`WEST_NUM_PADS-1:0] pd;
        logic [`WEST_NUM_PADS-1:0] ppen;
        logic [`WEST_NUM_PADS-1:0] prg_slew;
        logic [`WEST_NUM_PADS-1:0] puq;
        logic [`WEST_NUM_PADS-1:0] pwrup_pull_en;
        logic [`WEST_NUM_PADS-1:0] pwrupzhl;
    } pad_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/pad_xbar_west.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module pad_xbar_west
    import west_pkg::*;
(
    input  logic [`WEST_NUM_PADS-1:0] outi,
    output pad_ctrl_t                 pads,
    input  macro_stat_t               stat,
    input  macro_ctrl_t               ctrl,
    output logic                      clk,
    output logic                      rst_n,
    output cfg_write_t                wr
);

    // Input pads
    localparam int pad_clk   = 0;
    localparam int pad_rst_n = 1;
    localparam int pad_valid = 2;
    localparam int pad_addr  = 3;
    localparam int pad_data  = 8;

    // Output pads
    localparam int pad_clkro   = 19;
    localparam int pad_lock    = 21;
    localparam int pad_clkpll  = 22;
    localparam int pad_clkpll0 = 23;
    localparam int pad_clkpll1 = 24;
    localparam int pad_iout    = 30;

    localparam logic [`WEST_NUM_PADS-1:0] out_mask =
        (`WEST_NUM_PADS'(1) << pad_clkro)   |
        (`WEST_NUM_PADS'(1) << pad_lock)    |
        (`WEST_NUM_PADS'(1) << pad_clkpll)  |
        (`WEST_NUM_PADS'(1) << pad_clkpll0) |
        (`WEST_NUM_PADS'(1) << pad_clkpll1) |
        (`WEST_NUM_PADS'(1) << pad_iout);

    logic [`WEST_NUM_PADS-1:0] out_level;

    // Macro returns placed on their pad positions
    always_comb begin
        out_level              = '0;
        out_level[pad_clkro]   = stat.clkro;
        out_level[pad_lock]    = stat.lock;
        out_level[pad_clkpll]  = stat.clkpll;
        out_level[pad_clkpll0] = stat.clkpll0;
        out_level[pad_clkpll1] = stat.clkpll1;
        out_level[pad_iout]    = stat.iout;
    end

    // Controls are fixed by pad direction
    always_comb begin
        pads               = '0;
        pads.dq            = ~out_level & out_mask;
        pads.enabq         = out_mask;
        pads.enq           = ~out_mask;
        pads.ppen          = out_mask;
        pads.puq           = '1;
        pads.drv0          = '0;
        pads.drv1          = '0;
        pads.drv2          = '0;
        pads.pd            = '0;
        pads.prg_slew      = '0;
        pads.pwrup_pull_en = '0;
        pads.pwrupzhl      = '0;
    end

    assign clk   = outi[pad_clk];
    assign rst_n = outi[pad_rst_n];

    assign wr = '{
        valid: outi[pad_valid],
        addr:  outi[pad_addr +: `WEST_ADDR_W],
        data:  outi[pad_data +: `WEST_DATA_W]
    };

endmodule

`default_nettype wire

//--- rtl/cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module cfg_regs
    import west_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cfg_write_t wr,
    output west_cfg_t  cfg
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else begin
            // Seed load lasts a single cycle
            cfg.seed_load <= 1'b0;

            if (wr.valid) begin
                case (wr.addr)
                    `WEST_REG_CTRL: begin
                        cfg.trng_en  <= wr.data[`WEST_CTRL_TRNG_EN];
                        cfg.noise_en <= wr.data[`WEST_CTRL_NOISE_EN];
                        cfg.ref_en   <= wr.data[`WEST_CTRL_REF_EN];
                    end
                    `WEST_REG_REFDIV: begin
                        cfg.ref_div <= wr.data;
                    end
                    `WEST_REG_VB: begin
                        cfg.vb <= wr.data[`WEST_VB_W-1:0];
                    end
                    `WEST_REG_SEED: begin
                        cfg.seed      <= wr.data;
                        cfg.seed_load <= 1'b1;
                    end
                    default: begin
                        // Unmapped address, write dropped
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/macro_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module macro_clk_gen
    import west_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  west_cfg_t cfg,
    output logic      clkref,
    output logic      clktrng
);

    logic [`WEST_DATA_W-1:0] div_cnt;
    logic [`WEST_DATA_W-1:0] ref_div_q;
    logic                    ref_en_q;
    logic                    restart;

    // A new enable or divider value starts a fresh count
    assign restart = (cfg.ref_en != ref_en_q) || (cfg.ref_div != ref_div_q);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            ref_div_q <= '0;
            ref_en_q  <= 1'b0;
            clkref    <= 1'b0;
        end else begin
            ref_en_q  <= cfg.ref_en;
            ref_div_q <= cfg.ref_div;

            if (!cfg.ref_en) begin
                div_cnt <= '0;
                clkref  <= 1'b0;
            end else if (restart) begin
                div_cnt <= '0;
            end else if (div_cnt == cfg.ref_div) begin
                div_cnt <= '0;
                clkref  <= ~clkref;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // TRNG clock runs at half the core clock
    always_ff @(posedge clk) begin
        if (!rst_n || !cfg.trng_en) begin
            clktrng <= 1'b0;
        end else begin
            clktrng <= ~clktrng;
        end
    end

endmodule

`default_nettype wire

//--- rtl/noise_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module noise_lfsr
    import west_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  west_cfg_t cfg,
    output logic      clknoise
);

    logic [`WEST_DATA_W-1:0] lfsr;
    logic                    feedback;

    // Taps at bits 9 and 6
    assign feedback = lfsr[9] ^ lfsr[6];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= '0;
        end else if (cfg.seed_load) begin
            // All-zero state would lock up the register
            if (cfg.seed == '0) begin
                lfsr <= `WEST_DATA_W'(1);
            end else begin
                lfsr <= cfg.seed;
            end
        end else if (cfg.noise_en) begin
            lfsr <= {lfsr[`WEST_DATA_W-2:0], feedback};
        end
    end

    assign clknoise = lfsr[`WEST_DATA_W-1];

endmodule

`default_nettype wire

//--- rtl/chip_west_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module chip_west_top
    import west_pkg::*;
(
    input  logic [`WEST_NUM_PADS-1:0] outi,
    output pad_ctrl_t                 pads,
    input  macro_stat_t               stat,
    output macro_ctrl_t               ctrl
);

    logic       clk;
    logic       rst_n;
    cfg_write_t wr;
    west_cfg_t  cfg;
    logic       clkref;
    logic       clktrng;
    logic       clknoise;

    pad_xbar_west i_pad_xbar_west (
        .outi  (outi),
        .pads  (pads),
        .stat  (stat),
        .ctrl  (ctrl),
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr)
    );

    cfg_regs i_cfg_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .cfg   (cfg)
    );

    macro_clk_gen i_macro_clk_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .clkref  (clkref),
        .clktrng (clktrng)
    );

    noise_lfsr i_noise_lfsr (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .clknoise (clknoise)
    );

    // Bias word goes to the macros straight from the register
    assign ctrl = '{
        clktrng:  clktrng,
        clkref:   clkref,
        clknoise: clknoise,
        vb:       cfg.vb
    };

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // Reset released on a falling edge, like the other pad inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/chip_west_chk.sv
`timescale 1ns/1ps
`default_nettype none

module chip_west_chk
    import west_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input pad_ctrl_t   pads,
    input macro_ctrl_t ctrl,
    input cfg_write_t  wr,
    input west_cfg_t   cfg
);

    int   error_count = 0;
    logic written;

    // Set by the first write strobe after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            written <= 1'b0;
        end else if (wr.valid) begin
            written <= 1'b1;
        end
    end

    // Every pad has its input or its output buffer enabled
    pad_dir_a: assert property (@(posedge clk) &(pads.enq | pads.enabq))
    else begin
        error_count++;
        $error("enq and enabq both low on pads %h", ~(pads.enq | pads.enabq));
    end

    ctrl_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        !written |-> ctrl == '0)
    else begin
        error_count++;
        $error("macro drive %h active before any write", ctrl);
    end

    trng_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg.trng_en |=> !ctrl.clktrng)
    else begin
        error_count++;
        $error("clktrng high while trng_en is clear");
    end

endmodule

bind chip_west_top chip_west_chk i_chip_west_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .pads  (pads),
    .ctrl  (ctrl),
    .wr    (wr),
    .cfg   (cfg)
);

`default_nettype wire

//--- tests/chip_west_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "west_defines.svh"

module chip_west_tb
    import west_pkg::*;
();

    localparam int op_write    = 1;
    localparam int op_stat     = 2;
    localparam int op_run      = 3;
    localparam int op_vb       = 4;
    localparam int op_end      = 15;
    localparam int max_vectors = 64;

    // Output pads 19, 21, 22, 23, 24 and 30
    localparam logic [`WEST_NUM_PADS-1:0] out_pads = 32'h41e8_0000;

    logic                    clk;
    logic                    rst_n;
    logic [`WEST_NUM_PADS-1:0] outi;
    cfg_write_t              cur_wr;
    macro_stat_t             stat;
    pad_ctrl_t               pads;
    macro_ctrl_t             ctrl;
    logic [23:0]             vectors [0:max_vectors-1];
    integer                  seed = 32'hc9284bf8;
    int                      cycle_cnt = 0;
    int                      timeout_cycles = 0;

    // Reference model of the configuration and the generators
    west_cfg_t               exp_cfg;
    logic                    exp_clkref;
    logic                    exp_clktrng;
    logic [`WEST_DATA_W-1:0] exp_lfsr;
    logic                    ref_restart;
    int                      ref_wait;

    tb_clk_gen i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    always_comb begin
        outi      = '0;
        outi[0]   = clk;
        outi[1]   = rst_n;
        outi[2]   = cur_wr.valid;
        outi[7:3] = cur_wr.addr;
        outi[17:8] = cur_wr.data;
    end

    chip_west_top i_chip_west_top (
        .outi (outi),
        .pads (pads),
        .stat (stat),
        .ctrl (ctrl)
    );

    task automatic end_with_fail();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_pads(input string name, input pad_ctrl_t exp, input pad_ctrl_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            end_with_fail();
        end
    endtask

    task automatic check_ctrl(input string name, input macro_ctrl_t exp,
                              input macro_ctrl_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            end_with_fail();
        end
    endtask

    function automatic macro_ctrl_t expected_ctrl();
        return '{clktrng: exp_clktrng, clkref: exp_clkref,
                 clknoise: exp_lfsr[`WEST_DATA_W-1], vb: exp_cfg.vb};
    endfunction

    function automatic pad_ctrl_t expected_pads(input macro_stat_t s);
        pad_ctrl_t p;
        p         = '0;
        p.dq[19]  = ~s.clkro;
        p.dq[21]  = ~s.lock;
        p.dq[22]  = ~s.clkpll;
        p.dq[23]  = ~s.clkpll0;
        p.dq[24]  = ~s.clkpll1;
        p.dq[30]  = ~s.iout;
        p.enq     = ~out_pads;
        p.enabq   = out_pads;
        p.ppen    = out_pads;
        p.puq     = '1;
        return p;
    endfunction

    // One rising edge of the model, fed by the write currently on the pads
    task automatic advance_model();
        if (!exp_cfg.ref_en) begin
            exp_clkref = 1'b0;
        end else if (ref_restart) begin
            ref_wait = int'(exp_cfg.ref_div) + 1;
        end else begin
            ref_wait = ref_wait - 1;
            if (ref_wait == 0) begin
                exp_clkref = ~exp_clkref;
                ref_wait   = int'(exp_cfg.ref_div) + 1;
            end
        end
        exp_clktrng = exp_cfg.trng_en ? ~exp_clktrng : 1'b0;
        if (exp_cfg.seed_load) begin
            exp_lfsr = (exp_cfg.seed == '0) ? `WEST_DATA_W'(1) : exp_cfg.seed;
        end else if (exp_cfg.noise_en) begin
            exp_lfsr = {exp_lfsr[8:0], exp_lfsr[9] ^ exp_lfsr[6]};
        end
        ref_restart       = 1'b0;
        exp_cfg.seed_load = 1'b0;
        if (cur_wr.valid) begin
            case (cur_wr.addr)
                `WEST_REG_CTRL: begin
                    ref_restart      = cur_wr.data[`WEST_CTRL_REF_EN] != exp_cfg.ref_en;
                    exp_cfg.trng_en  = cur_wr.data[`WEST_CTRL_TRNG_EN];
                    exp_cfg.noise_en = cur_wr.data[`WEST_CTRL_NOISE_EN];
                    exp_cfg.ref_en   = cur_wr.data[`WEST_CTRL_REF_EN];
                end
                `WEST_REG_REFDIV: begin
                    ref_restart     = cur_wr.data != exp_cfg.ref_div;
                    exp_cfg.ref_div = cur_wr.data;
                end
                `WEST_REG_VB: begin
                    exp_cfg.vb = cur_wr.data[`WEST_VB_W-1:0];
                end
                `WEST_REG_SEED: begin
                    exp_cfg.seed      = cur_wr.data;
                    exp_cfg.seed_load = 1'b1;
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic step_cycle(input string name);
        @(posedge clk);
        advance_model();
        @(negedge clk);
        check_ctrl(name, expected_ctrl(), ctrl);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_cycles) begin
            $display("TIMEOUT: run did not finish within %0d clock cycles", timeout_cycles);
            end_with_fail();
        end
    end

    // Assertion failures in the bound checker end the run at once
    always @(negedge clk) begin
        if (i_chip_west_top.i_chip_west_chk.error_count != 0) begin
            $display("Bound checker reported %0d assertion failures",
                     i_chip_west_top.i_chip_west_chk.error_count);
            end_with_fail();
        end
    end

    initial begin
        int          idx;
        logic [31:0] rnd;
        macro_ctrl_t exp_c;
        cur_wr      = '0;
        stat        = '0;
        exp_cfg     = '0;
        exp_clkref  = 1'b0;
        exp_clktrng = 1'b0;
        exp_lfsr    = '0;
        ref_restart = 1'b0;
        ref_wait    = 0;
        for (idx = 0; idx < max_vectors; idx++) begin
            vectors[idx] = {4'hf, 20'(idx)};
        end
        $readmemh("tests/west_vectors.txt", vectors);
        if (vectors[0][23:20] == op_end) begin
            $display("Vector file is missing or holds no commands");
            end_with_fail();
        end
        // Reset and release, then the vector cycles, then margin
        timeout_cycles = 104;
        for (idx = 0; idx < max_vectors && vectors[idx][23:20] != op_end; idx++) begin
            if (vectors[idx][23:20] == op_run) begin
                timeout_cycles += int'(vectors[idx][11:0]);
            end else if (vectors[idx][23:20] != op_vb) begin
                timeout_cycles += 1;
            end
        end

        wait (rst_n === 1'b1);
        check_ctrl("after reset", expected_ctrl(), ctrl);

        idx = 0;
        while (idx < max_vectors && vectors[idx][23:20] != op_end) begin
            case (int'(vectors[idx][23:20]))
                op_write: begin
                    cur_wr = '{valid: 1'b1, addr: vectors[idx][16:12], data: vectors[idx][9:0]};
                    step_cycle($sformatf("write vector %0d", idx));
                    cur_wr.valid = 1'b0;
                end
                op_stat: begin
                    rnd  = $random(seed);
                    stat = rnd[5:0];
                    step_cycle($sformatf("status vector %0d", idx));
                    check_pads($sformatf("pads vector %0d", idx), expected_pads(stat), pads);
                end
                op_run: begin
                    for (int n = 0; n < int'(vectors[idx][11:0]); n++) begin
                        step_cycle($sformatf("run vector %0d cycle %0d", idx, n));
                    end
                end
                op_vb: begin
                    exp_c    = expected_ctrl();
                    exp_c.vb = vectors[idx][`WEST_VB_W-1:0];
                    check_ctrl($sformatf("vb vector %0d", idx), exp_c, ctrl);
                end
                default: begin
                    $display("Unknown command %h in vector %0d", vectors[idx], idx);
                    end_with_fail();
                end
            endcase
            idx++;
        end

        if (i_chip_west_top.i_chip_west_chk.error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d assertion failures in the bound checker",
                     i_chip_west_top.i_chip_west_chk.error_count);
            end_with_fail();
        end
    end

endmodule

`default_nettype wire

//--- tests/west_vectors.txt
// One hex word per line: op[23:20] addr[19:12] data[11:0]
// op 1 write, 2 random macro status and pad check, 3 run data cycles, 4 expect ctrl.vb = data
200000
200000
102005
400005
10700a
400005
11f3ff
400005
300003
101000
100004
300010
101003
300020
101002
300018
100005
30000a
100004
300006
1032a5
100002
300030
100000
300008
103000
100002
300020
100007
300010
10200a
40000a
200000
200000

//--- list.f
+incdir+rtl
rtl/west_pkg.sv
rtl/pad_xbar_west.sv
rtl/cfg_regs.sv
rtl/macro_clk_gen.sv
rtl/noise_lfsr.sv
rtl/chip_west_top.sv
tests/tb_clk_gen.sv
tests/chip_west_chk.sv
tests/chip_west_tb.sv
